// ==== hdl/frame_fifo_pkg.sv ====
// shared widths, depth, beat struct, pointer type and write-state enum for the frame FIFO
package frame_fifo_pkg;

  // stream data width
  localparam int data_w = 8;

  // storage address width, depth follows from it
  localparam int fifo_aw = 4;
  localparam int fifo_depth = 1 << fifo_aw;

  // one extra msb so a full FIFO can be told from an empty one
  typedef logic [fifo_aw:0] ptr_t;

  // one stream beat, used on both ports and in the storage array
  typedef struct packed {
    logic [data_w-1:0] data;
    logic              last;
    logic              bad;
  } beat_t;

  // write side frame tracking
  typedef enum logic [1:0] {
    // between frames
    wr_idle  = 2'd0,
    // storing the current frame
    wr_store = 2'd1,
    // discarding the rest of an oversize frame
    wr_drop  = 2'd2
  } wr_state_e;

endpackage

// ==== hdl/frame_write_ctrl.sv ====
// write-side FSM that the top level uses to store, commit, rewind or drop each input beat
`timescale 1ns/100ps

module frame_write_ctrl
  import frame_fifo_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  beat_t in_beat,
  input  logic  in_valid,
  input  logic  full,
  input  logic  full_wr,
  output logic  in_ready,
  output logic  store,
  output logic  commit,
  output logic  rewind,
  output logic  status_good,
  output logic  status_bad,
  output logic  status_overflow
);

  wr_state_e state;

  logic accept;
  logic drop_beat;
  logic last_beat;

  // a frame that alone fills the FIFO keeps flowing so it can be thrown away
  assign in_ready = !full || full_wr;

  assign accept = in_valid && in_ready;
  assign last_beat = accept && in_beat.last;

  // oversize frame just detected or already being dropped
  assign drop_beat = full_wr || (state == wr_drop);

  assign store = accept && !drop_beat;

  // good last beat makes the frame visible to the read side
  assign commit = store && in_beat.last && !in_beat.bad;

  // discard the whole frame on a bad marker or after an overflow
  assign rewind = last_beat && (drop_beat || in_beat.bad);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= wr_idle;
    end else if (accept) begin
      if (in_beat.last) begin
        state <= wr_idle;
      end else if (drop_beat) begin
        state <= wr_drop;
      end else begin
        state <= wr_store;
      end
    end
  end

  // one-cycle status pulses after the last beat
  always_ff @(posedge clk) begin
    if (rst) begin
      status_good     <= 1'b0;
      status_bad      <= 1'b0;
      status_overflow <= 1'b0;
    end else begin
      status_good     <= commit;
      status_bad      <= store && in_beat.last && in_beat.bad;
      status_overflow <= last_beat && drop_beat;
    end
  end

  // a frame either becomes visible or is discarded but never both
  a_commit_rewind_excl: assert property (
    @(posedge clk) disable iff (rst)
    !(commit && rewind)
  );

endmodule

// ==== hdl/fifo_pointers.sv ====
// pointer counters of the frame FIFO, giving the top level its full, empty and depth status
`timescale 1ns/100ps

module fifo_pointers
  import frame_fifo_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic store,
  input  logic commit,
  input  logic rewind,
  input  logic rd_advance,
  output ptr_t wr_addr,
  output ptr_t rd_addr,
  output logic full,
  output logic full_wr,
  output logic has_data,
  output ptr_t status_depth,
  output ptr_t status_depth_commit
);

  ptr_t wr_ptr;
  ptr_t commit_ptr;
  ptr_t rd_ptr;

  ptr_t fill;
  ptr_t fill_commit;

  assign wr_addr = wr_ptr;
  assign rd_addr = rd_ptr;

  // full when only the wrap bit differs
  assign full    = wr_ptr == (rd_ptr ^ ptr_t'(fifo_depth));
  // current frame alone occupies the whole array
  assign full_wr = wr_ptr == (commit_ptr ^ ptr_t'(fifo_depth));

  // only committed beats are readable
  assign has_data = commit_ptr != rd_ptr;

  assign fill        = wr_ptr - rd_ptr;
  assign fill_commit = commit_ptr - rd_ptr;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      commit_ptr <= '0;
    end else begin
      // rewind wins over a store of the same beat
      if (rewind) begin
        wr_ptr <= commit_ptr;
      end else if (store) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (commit) begin
        commit_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
    end else if (rd_advance) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // depth status lags the pointers by one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      status_depth        <= '0;
      status_depth_commit <= '0;
    end else begin
      status_depth        <= fill;
      status_depth_commit <= fill_commit;
    end
  end

  // writer never laps the reader
  a_fill_bounded: assert property (
    @(posedge clk) disable iff (rst)
    fill <= ptr_t'(fifo_depth)
  );

endmodule

// ==== hdl/frame_ram.sv ====
// frame storage array with a single registered read stage feeding the output path
`timescale 1ns/100ps

module frame_ram
  import frame_fifo_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  store,
  input  ptr_t  wr_addr,
  input  beat_t in_beat,
  input  ptr_t  rd_addr,
  input  logic  has_data,
  input  logic  ram_ready,
  output beat_t ram_beat,
  output logic  ram_valid,
  output logic  rd_advance
);

  beat_t mem [fifo_depth];

  // output register free or being drained this cycle
  assign rd_advance = has_data && (!ram_valid || ram_ready);

  always_ff @(posedge clk) begin
    if (store) begin
      mem[wr_addr[fifo_aw-1:0]] <= in_beat;
    end
  end

  // beat payload, only the valid bit needs a reset
  always_ff @(posedge clk) begin
    if (rd_advance) begin
      ram_beat <= mem[rd_addr[fifo_aw-1:0]];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ram_valid <= 1'b0;
    end else if (rd_advance) begin
      ram_valid <= 1'b1;
    end else if (ram_ready) begin
      ram_valid <= 1'b0;
    end
  end

  // held beat survives back-pressure unchanged
  a_hold_stable: assert property (
    @(posedge clk) disable iff (rst)
    (ram_valid && !ram_ready) |=> (ram_valid && $stable(ram_beat))
  );

endmodule

// ==== hdl/frame_pause_gate.sv ====
// output gate that applies a pause request only on a frame boundary
`timescale 1ns/100ps

module frame_pause_gate
  import frame_fifo_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  beat_t ram_beat,
  input  logic  ram_valid,
  input  logic  out_ready,
  input  logic  pause_req,
  output logic  ram_ready,
  output beat_t out_beat,
  output logic  out_valid,
  output logic  pause_ack
);

  logic in_frame;
  logic xfer;
  logic xfer_last;
  logic at_boundary;

  // paused output hides valid and blocks the upstream stage
  assign out_beat  = ram_beat;
  assign out_valid = ram_valid && !pause_ack;
  assign ram_ready = out_ready && !pause_ack;

  assign xfer      = out_valid && out_ready;
  assign xfer_last = xfer && ram_beat.last;

  // nothing presented and nothing started, or the frame closes now
  assign at_boundary = xfer_last || (!in_frame && !ram_valid);

  always_ff @(posedge clk) begin
    if (rst) begin
      in_frame <= 1'b0;
    end else if (xfer_last) begin
      in_frame <= 1'b0;
    end else if (out_valid) begin
      in_frame <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pause_ack <= 1'b0;
    end else if (pause_ack || at_boundary) begin
      pause_ack <= pause_req;
    end
  end

  // pause takes hold only between frames
  a_pause_on_boundary: assert property (
    @(posedge clk) disable iff (rst)
    $rose(pause_ack) |-> $past(!in_frame || xfer_last)
  );

endmodule

// ==== hdl/frame_fifo_top.sv ====
// frame FIFO top level, connects write FSM, pointers, storage and pause gate
`timescale 1ns/100ps

module frame_fifo_top
  import frame_fifo_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  beat_t in_beat,
  input  logic  in_valid,
  output logic  in_ready,
  output beat_t out_beat,
  output logic  out_valid,
  input  logic  out_ready,
  input  logic  pause_req,
  output logic  pause_ack,
  output ptr_t  status_depth,
  output ptr_t  status_depth_commit,
  output logic  status_good,
  output logic  status_bad,
  output logic  status_overflow
);

  logic  store;
  logic  commit;
  logic  rewind;
  logic  full;
  logic  full_wr;
  logic  has_data;
  logic  rd_advance;
  ptr_t  wr_addr;
  ptr_t  rd_addr;
  beat_t ram_beat;
  logic  ram_valid;
  logic  ram_ready;

  frame_write_ctrl u_write_ctrl (
    .clk             (clk),
    .rst             (rst),
    .in_beat         (in_beat),
    .in_valid        (in_valid),
    .full            (full),
    .full_wr         (full_wr),
    .in_ready        (in_ready),
    .store           (store),
    .commit          (commit),
    .rewind          (rewind),
    .status_good     (status_good),
    .status_bad      (status_bad),
    .status_overflow (status_overflow)
  );

  fifo_pointers u_pointers (
    .clk                 (clk),
    .rst                 (rst),
    .store               (store),
    .commit              (commit),
    .rewind              (rewind),
    .rd_advance          (rd_advance),
    .wr_addr             (wr_addr),
    .rd_addr             (rd_addr),
    .full                (full),
    .full_wr             (full_wr),
    .has_data            (has_data),
    .status_depth        (status_depth),
    .status_depth_commit (status_depth_commit)
  );

  frame_ram u_ram (
    .clk        (clk),
    .rst        (rst),
    .store      (store),
    .wr_addr    (wr_addr),
    .in_beat    (in_beat),
    .rd_addr    (rd_addr),
    .has_data   (has_data),
    .ram_ready  (ram_ready),
    .ram_beat   (ram_beat),
    .ram_valid  (ram_valid),
    .rd_advance (rd_advance)
  );

  frame_pause_gate u_pause_gate (
    .clk       (clk),
    .rst       (rst),
    .ram_beat  (ram_beat),
    .ram_valid (ram_valid),
    .out_ready (out_ready),
    .pause_req (pause_req),
    .ram_ready (ram_ready),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .pause_ack (pause_ack)
  );

endmodule

// ==== testbench/frame_fifo_tb.sv ====
// frame FIFO testbench that runs random frames through the top level against a scoreboard queue
`timescale 1ns/100ps

module frame_fifo_tb
  import frame_fifo_pkg::*;
();

  localparam int timeout_cycles = 2000;

  logic  clk;
  logic  rst;
  beat_t in_beat;
  logic  in_valid;
  logic  in_ready;
  beat_t out_beat;
  logic  out_valid;
  logic  out_ready;
  logic  pause_req;
  logic  pause_ack;
  ptr_t  status_depth;
  ptr_t  status_depth_commit;
  logic  status_good;
  logic  status_bad;
  logic  status_overflow;

  // beats of frames that must reach the output in arrival order
  beat_t exp_q[$];
  beat_t exp_head;
  int    exp_count;

  string      test_name;
  int         ready_pct;
  logic       oversize_active;
  // expected {good, bad, overflow} of the frame being sent and of the last closed one
  logic [2:0] exp_status;
  logic [2:0] closed_status;
  logic       out_mid_frame;
  int         good_expected;
  int         good_seen;

  initial clk = 1'b0;
  always #10 clk = ~clk;

  frame_fifo_top u_dut (
    .clk                 (clk),
    .rst                 (rst),
    .in_beat             (in_beat),
    .in_valid            (in_valid),
    .in_ready            (in_ready),
    .out_beat            (out_beat),
    .out_valid           (out_valid),
    .out_ready           (out_ready),
    .pause_req           (pause_req),
    .pause_ack           (pause_ack),
    .status_depth        (status_depth),
    .status_depth_commit (status_depth_commit),
    .status_good         (status_good),
    .status_bad          (status_bad),
    .status_overflow     (status_overflow)
  );

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic value_mismatch(input string what, input int unsigned expected,
                                input int unsigned actual);
    stop_run($sformatf("mismatch in test %s, %s: expected %0h, actual %0h",
                       test_name, what, expected, actual));
  endtask

  task automatic check_failed(input string what);
    stop_run($sformatf("error in test %s: %s", test_name, what));
  endtask

  function automatic void refresh_head();
    exp_count = exp_q.size();
    exp_head  = (exp_count > 0) ? exp_q[0] : '0;
  endfunction

  // random out_ready with ready_pct percent of cycles high
  always @(negedge clk) begin
    out_ready = ($urandom_range(99) < ready_pct);
  end

  // scoreboard pops one beat per output transfer
  always @(posedge clk) begin
    if (rst) begin
      out_mid_frame <= 1'b0;
      closed_status <= 3'b000;
      good_seen     <= 0;
    end else begin
      if (out_valid && out_ready) begin
        if (exp_q.size() > 0) begin
          void'(exp_q.pop_front());
        end
        refresh_head();
        out_mid_frame <= !out_beat.last;
      end
      if (in_valid && in_ready && in_beat.last) begin
        closed_status <= exp_status;
      end
      if (status_good) begin
        good_seen <= good_seen + 1;
      end
    end
  end

  a_out_expected: assert property (
    @(posedge clk) disable iff (rst)
    (out_valid && out_ready) |-> (exp_count > 0)
  ) else check_failed("output beat arrived with no frame pending");

  a_out_data: assert property (
    @(posedge clk) disable iff (rst)
    (out_valid && out_ready && exp_count > 0) |-> (out_beat == exp_head)
  ) else value_mismatch("output beat", $sampled(exp_head), $sampled(out_beat));

  a_out_stable: assert property (
    @(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_beat))
  ) else check_failed("output beat dropped or changed under back-pressure");

  // one pulse of the right kind right after each closing beat
  a_status_match: assert property (
    @(posedge clk) disable iff (rst)
    (in_valid && in_ready && in_beat.last) |=>
      ({status_good, status_bad, status_overflow} == closed_status)
  ) else value_mismatch("status pulses", $sampled(closed_status),
                        $sampled({status_good, status_bad, status_overflow}));

  a_status_source: assert property (
    @(posedge clk) disable iff (rst)
    (status_good || status_bad || status_overflow) |->
      $past(in_valid && in_ready && in_beat.last)
  ) else check_failed("status pulse without a closing input beat");

  a_oversize_ready: assert property (
    @(posedge clk) disable iff (rst)
    (oversize_active && in_valid) |-> in_ready
  ) else check_failed("in_ready dropped during an oversize frame");

  a_pause_blocks: assert property (
    @(posedge clk) disable iff (rst)
    pause_ack |-> !out_valid
  ) else check_failed("out_valid high while paused");

  a_pause_boundary: assert property (
    @(posedge clk) disable iff (rst)
    $rose(pause_ack) |-> !out_mid_frame
  ) else check_failed("pause_ack rose inside an output frame");

  a_depth_range: assert property (
    @(posedge clk) disable iff (rst)
    (status_depth <= ptr_t'(fifo_depth)) && (status_depth_commit <= status_depth)
  ) else check_failed("depth status out of range");

  task automatic send_beat(input beat_t beat);
    int waited;
    waited   = 0;
    in_beat  = beat;
    in_valid = 1'b1;
    // in_ready only moves on a rising edge and is settled here
    while (!in_ready && waited < timeout_cycles) begin
      @(negedge clk);
      waited++;
    end
    if (!in_ready) begin
      check_failed("input beat not accepted before timeout");
    end
    @(negedge clk);
  endtask

  task automatic send_frame(input int len, input logic bad_last);
    beat_t beat;
    beat_t frame[$];
    int    i;
    // classify by rule before the first beat goes in
    if (bad_last) begin
      exp_status = 3'b010;
    end else if (len > fifo_depth) begin
      exp_status = 3'b001;
    end else begin
      exp_status = 3'b100;
    end
    for (i = 0; i < len; i++) begin
      beat.data = data_w'($urandom());
      beat.last = (i == len - 1);
      beat.bad  = bad_last && (i == len - 1);
      frame.push_back(beat);
    end
    if (exp_status == 3'b100) begin
      foreach (frame[k]) begin
        exp_q.push_back(frame[k]);
      end
      good_expected++;
      refresh_head();
    end
    foreach (frame[k]) begin
      send_beat(frame[k]);
    end
    in_valid = 1'b0;
  endtask

  task automatic drain_output();
    int waited;
    waited = 0;
    while ((exp_count > 0 || out_valid) && waited < timeout_cycles) begin
      @(negedge clk);
      waited++;
    end
    if (exp_count > 0 || out_valid) begin
      check_failed("expected frames did not drain before timeout");
    end
  endtask

  initial begin
    int len;
    int waited;
    void'($urandom(17));
    rst             = 1'b1;
    in_valid        = 1'b0;
    in_beat         = '0;
    out_ready       = 1'b0;
    pause_req       = 1'b0;
    ready_pct       = 100;
    oversize_active = 1'b0;
    exp_status      = 3'b000;
    good_expected   = 0;
    test_name       = "reset";
    refresh_head();
    repeat (5) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    assert (!out_valid && !pause_ack) else check_failed("output active after reset");
    assert (!status_good && !status_bad && !status_overflow)
      else check_failed("status pulse right after reset");
    assert (status_depth == 0) else value_mismatch("depth after reset", 0, status_depth);
    assert (status_depth_commit == 0)
      else value_mismatch("committed depth after reset", 0, status_depth_commit);
    assert (in_ready) else check_failed("in_ready low after reset");

    test_name = "good frames";
    ready_pct = 70;
    for (len = 1; len <= fifo_depth; len++) begin
      send_frame(len, 1'b0);
    end
    drain_output();

    test_name = "bad frame";
    send_frame(5, 1'b0);
    send_frame(7, 1'b1);
    send_frame(3, 1'b0);
    drain_output();

    test_name = "oversize frame";
    ready_pct = 100;
    oversize_active = 1'b1;
    send_frame(fifo_depth + 4, 1'b0);
    oversize_active = 1'b0;
    send_frame(4, 1'b0);
    drain_output();

    test_name = "full fifo";
    ready_pct = 0;
    send_frame(8, 1'b0);
    send_frame(8, 1'b0);
    // the output register holds one beat so a third frame fills the array
    send_frame(1, 1'b0);
    waited = 0;
    while (status_depth_commit != ptr_t'(fifo_depth) && waited < timeout_cycles) begin
      @(negedge clk);
      waited++;
    end
    if (status_depth_commit != ptr_t'(fifo_depth)) begin
      check_failed("committed depth never reached a full FIFO");
    end
    assert (!in_ready) else check_failed("in_ready high with the FIFO full");
    assert (status_depth == ptr_t'(fifo_depth))
      else value_mismatch("depth when full", fifo_depth, status_depth);
    ready_pct = 50;
    drain_output();

    test_name = "pause";
    ready_pct = 100;
    send_frame(10, 1'b0);
    waited = 0;
    while (!out_mid_frame && waited < timeout_cycles) begin
      @(negedge clk);
      waited++;
    end
    if (!out_mid_frame) begin
      check_failed("output frame never started");
    end
    pause_req = 1'b1;
    send_frame(6, 1'b0);
    waited = 0;
    while (!pause_ack && waited < timeout_cycles) begin
      @(negedge clk);
      waited++;
    end
    if (!pause_ack) begin
      check_failed("pause_ack never rose after the frame ended");
    end
    // only the frame sent after the pause request is still held
    assert (exp_count == 6) else value_mismatch("beats held by pause", 6, exp_count);
    repeat (10) @(negedge clk);
    assert (exp_count == 6) else value_mismatch("beats held during pause", 6, exp_count);
    pause_req = 1'b0;
    drain_output();

    test_name = "summary";
    if (good_seen == good_expected) begin
      $display("All tests passed");
      $finish;
    end else begin
      value_mismatch("status_good pulse count", good_expected, good_seen);
    end
  end

endmodule

// ==== src.f ====
hdl/frame_fifo_pkg.sv
hdl/frame_write_ctrl.sv
hdl/fifo_pointers.sv
hdl/frame_ram.sv
hdl/frame_pause_gate.sv
hdl/frame_fifo_top.sv
testbench/frame_fifo_tb.sv
